//--- flist.f
design/udp_tx_pkg.sv
design/line_distributor.sv
design/line_buffer.sv
design/crc32_gen.sv
design/udp_frame_builder.sv
design/gmii_frame_mux.sv
design/video_udp_tx_top.sv
bench/frame_checker.sv
bench/video_udp_tx_tb.sv

//--- Bender.yml
package:
  name: video_udp_tx

sources:
  - design/udp_tx_pkg.sv
  - design/line_distributor.sv
  - design/line_buffer.sv
  - design/crc32_gen.sv
  - design/udp_frame_builder.sv
  - design/gmii_frame_mux.sv
  - design/video_udp_tx_top.sv
  - target: test
    files:
      - bench/frame_checker.sv
      - bench/video_udp_tx_tb.sv

//--- bench/video_udp_tx_tb.sv
`timescale 1ns/1ps

module video_udp_tx_tb;
	import udp_tx_pkg::*;

	localparam int NUM_LINES   = 8;
	localparam int FRM_BYTES   = 8 + 14 + 20 + 8 + 3 + 2 * PIX_PER_LINE + 4;
	localparam int WDOG_CYCLES = NUM_LINES * (FRM_BYTES + IFG_CYCLES + 2 * PIX_PER_LINE + 40);

	logic       fifo_clk;
	logic       sys_rst;
	logic       line_valid;
	line_word_u line_word;
	logic       gmii_tx_en;
	logic [7:0] gmii_txd;
	int         err_cnt;
	int         frm_cnt;
	int         line_cnt;
	int         bench_err;
	int         seed_val;

	// --------------------
	// Line number, first pixel value, idle cycles after the line
	// Lines 20, 22, 24 all land on channel 0 and fill its buffer
	int          tbl_ln   [NUM_LINES] = '{20, 22, 24, 25, 27, 26, 29, 28};
	logic [15:0] tbl_base [NUM_LINES] = '{16'h1000, 16'h2110, 16'h3220, 16'h4330,
		16'h5440, 16'h6550, 16'h7660, 16'h0770};
	int          tbl_gap  [NUM_LINES] = '{2, 100, 2, 2, 80, 80, 80, 2};

	video_udp_tx_top i_video_udp_tx_top (
		.fifo_clk   (fifo_clk),
		.sys_rst    (sys_rst),
		.line_valid (line_valid),
		.line_word  (line_word),
		.gmii_tx_en (gmii_tx_en),
		.gmii_txd   (gmii_txd)
	);

	frame_checker i_frame_checker (
		.fifo_clk   (fifo_clk),
		.sys_rst    (sys_rst),
		.line_valid (line_valid),
		.line_word  (line_word),
		.gmii_tx_en (gmii_tx_en),
		.gmii_txd   (gmii_txd),
		.err_cnt    (err_cnt),
		.frm_cnt    (frm_cnt),
		.line_cnt   (line_cnt)
	);

	always #50 fifo_clk = ~fifo_clk;

	// One valid word, then zero or one idle cycle
	task automatic send_word(input logic [15:0] w);
		int idle;
		idle = $urandom % 2;
		@(posedge fifo_clk);
		line_valid <= 1'b1;
		line_word  <= w;
		repeat (idle) begin
			@(posedge fifo_clk);
			line_valid <= 1'b0;
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge fifo_clk);
			line_valid <= 1'b0;
		end
	endtask

	initial begin
		int i;
		int p;
		fifo_clk   = 1'b0;
		sys_rst    = 1'b1;
		line_valid = 1'b0;
		line_word  = '0;
		bench_err  = 0;
		seed_val   = $urandom(32'h29d6);
		repeat (3) @(posedge fifo_clk);
		sys_rst <= 1'b0;
		for (i = 0; i < NUM_LINES; i++) begin
			send_word({HDR_TAG, 11'(tbl_ln[i])});
			for (p = 0; p < PIX_PER_LINE; p++) begin
				send_word(tbl_base[i] + 16'(p));
			end
			idle_cycles(tbl_gap[i]);
		end
		wait (frm_cnt >= NUM_LINES);
		// Quiet time so a stray extra frame still gets counted
		idle_cycles(2 * FRM_BYTES);
		if (frm_cnt != NUM_LINES) begin
			bench_err++;
			$display("Output carried %0d frames for %0d input lines", frm_cnt, NUM_LINES);
		end
		$display("Errors: %0d checker, %0d bench; frames %0d for %0d input lines",
			err_cnt, bench_err, frm_cnt, line_cnt);
		if (err_cnt == 0 && bench_err == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WDOG_CYCLES) @(posedge fifo_clk);
		$display("Timeout after %0d cycles with %0d of %0d frames seen",
			WDOG_CYCLES, frm_cnt, NUM_LINES);
		$display(">>> FAIL");
		$finish;
	end

endmodule

//--- bench/frame_checker.sv
`timescale 1ns/1ps

module frame_checker (
	input  logic                   fifo_clk,
	input  logic                   sys_rst,
	input  logic                   line_valid,
	input  udp_tx_pkg::line_word_u line_word,
	input  logic                   gmii_tx_en,
	input  logic [7:0]             gmii_txd,
	output int                     err_cnt,
	output int                     frm_cnt,
	output int                     line_cnt
);
	import udp_tx_pkg::*;

	localparam int MAX_LINES = 64;
	localparam int MAX_BYTES = 256;

	logic [LINE_NUM_W-1:0] ln_tab [MAX_LINES];
	logic [15:0]           px_tab [MAX_LINES][PIX_PER_LINE];
	int                    pend_q [$];
	int                    last_end [NUM_CH];
	logic [7:0]            rx [MAX_BYTES];
	logic [7:0]            exp_b [MAX_BYTES];
	int                    rx_n;
	int                    exp_n;
	int                    cyc;
	int                    start_cyc;
	int                    pix_cnt;
	logic [LINE_NUM_W-1:0] cur_ln;
	logic                  in_line;
	logic                  in_frm;
	logic                  early_seen;

	initial begin
		err_cnt    = 0;
		frm_cnt    = 0;
		line_cnt   = 0;
		early_seen = 1'b0;
		for (int k = 0; k < NUM_CH; k++) begin
			last_end[k] = -1000;
		end
	end

	task automatic put8(input logic [7:0] b);
		exp_b[exp_n] = b;
		exp_n++;
	endtask

	task automatic put16(input logic [15:0] w);
		put8(w[15:8]);
		put8(w[7:0]);
	endtask

	// --------------------
	// Expected frame for one line on one channel
	task automatic build_expected(input int ch, input int ent);
		logic [47:0] dst_mac;
		logic [47:0] src_mac;
		logic [15:0] hw [10];
		logic [19:0] sum;
		logic [31:0] c;
		int          i;
		int          b;
		dst_mac = {DST_MAC[47:8], DST_MAC[7:0] - 8'(ch)};
		src_mac = {SRC_MAC[47:8], SRC_MAC[7:0] + 8'(ch)};
		hw[0] = IP_VER_TOS;
		hw[1] = IP_LEN;
		hw[2] = IP_IDEN;
		hw[3] = IP_FLAG;
		hw[4] = {IP_TTL, IP_PROT};
		hw[5] = 16'h0000;
		hw[6] = IP_SRC[31:16];
		hw[7] = {IP_SRC[15:8], IP_SRC[7:0] + 8'(ch)};
		hw[8] = IP_DST[31:16];
		hw[9] = {IP_DST[15:8], IP_DST[7:0] - 8'(ch)};
		sum = '0;
		for (i = 0; i < 10; i++) begin
			sum = sum + 20'(hw[i]);
		end
		// End-around carry
		sum = 20'(sum[15:0]) + 20'(sum[19:16]);
		sum = 20'(sum[15:0]) + 20'(sum[19:16]);
		hw[5] = ~sum[15:0];
		exp_n = 0;
		for (i = 0; i < 7; i++) begin
			put8(8'h55);
		end
		put8(8'hD5);
		for (i = 5; i >= 0; i--) begin
			put8(dst_mac[i*8 +: 8]);
		end
		for (i = 5; i >= 0; i--) begin
			put8(src_mac[i*8 +: 8]);
		end
		put16(16'h0800);
		for (i = 0; i < 10; i++) begin
			put16(hw[i]);
		end
		put16(UDP_SRC_PORT);
		put16(UDP_DST_PORT);
		put16(UDP_LEN);
		put16(16'h0000);
		put8(PKT_VIDEO);
		put16(16'(ln_tab[ent]));
		// Luma is the upper byte, so it goes first
		for (i = 0; i < PIX_PER_LINE; i++) begin
			put16(px_tab[ent][i]);
		end
		// FCS covers everything after the SFD
		c = 32'hFFFF_FFFF;
		for (i = 8; i < exp_n; i++) begin
			c = c ^ 32'(exp_b[i]);
			for (b = 0; b < 8; b++) begin
				c = (c >> 1) ^ (32'hEDB8_8320 & {32{c[0]}});
			end
		end
		c = ~c;
		put8(c[7:0]);
		put8(c[15:8]);
		put8(c[23:16]);
		put8(c[31:24]);
	endtask

	// --------------------
	// Match a finished frame to the oldest line of its channel
	task automatic check_frame(input int end_cyc);
		int ch;
		int pos;
		int ent;
		int i;
		int low;
		ch  = -1;
		pos = -1;
		frm_cnt++;
		if (rx_n > 19) begin
			ch = int'(rx[19]) - int'(SRC_MAC[7:0]);
		end
		if (ch < 0 || ch >= NUM_CH) begin
			err_cnt++;
			$display("Frame ending at %0t has no valid channel in its source MAC", $time);
		end else begin
			for (i = 0; i < pend_q.size(); i++) begin
				if (pos < 0 && int'(ln_tab[pend_q[i]]) % NUM_CH == ch) begin
					pos = i;
				end
			end
			if (pos < 0) begin
				err_cnt++;
				$display("Frame at %0t from channel %0d has no pending input line", $time, ch);
			end else begin
				ent = pend_q[pos];
				pend_q.delete(pos);
				build_expected(ch, ent);
				if (rx_n != exp_n) begin
					err_cnt++;
					$display("Fail %0t gmii_tx_en length: got %0d, expected %0d",
						$time, rx_n, exp_n);
				end
				for (i = 0; i < exp_n && i < rx_n; i++) begin
					if (rx[i] !== exp_b[i]) begin
						err_cnt++;
						$display("Fail %0t gmii_txd[byte %0d] line %0d: got %h, expected %h",
							$time, i, ln_tab[ent], rx[i], exp_b[i]);
					end
				end
				low = start_cyc - last_end[ch] - 1;
				if (low < IFG_CYCLES) begin
					err_cnt++;
					$display("Fail %0t gmii_tx_en idle cycles ch%0d: got %0d, expected >= %0d",
						$time, ch, low, IFG_CYCLES);
				end
				last_end[ch] = end_cyc;
			end
		end
	endtask

	task automatic take_word(input line_word_u w);
		if (!in_line) begin
			if (w.hdr.tag == HDR_TAG) begin
				cur_ln  = w.hdr.num;
				pix_cnt = 0;
				in_line = 1'b1;
			end
		end else begin
			px_tab[line_cnt % MAX_LINES][pix_cnt] = w;
			pix_cnt++;
			if (pix_cnt == PIX_PER_LINE) begin
				ln_tab[line_cnt % MAX_LINES] = cur_ln;
				pend_q.push_back(line_cnt % MAX_LINES);
				line_cnt++;
				in_line = 1'b0;
			end
		end
	endtask

	always @(posedge fifo_clk) begin
		if (sys_rst) begin
			in_line = 1'b0;
			in_frm  = 1'b0;
			rx_n    = 0;
			cyc     = 0;
		end else begin
			cyc = cyc + 1;
			if (line_valid) begin
				take_word(line_word);
			end
			if (gmii_tx_en) begin
				if (!in_frm) begin
					start_cyc = cyc;
				end
				if (line_cnt == 0 && !early_seen) begin
					early_seen = 1'b1;
					err_cnt++;
					$display("gmii_tx_en went high at %0t before any line was complete", $time);
				end
				if (rx_n < MAX_BYTES) begin
					rx[rx_n] = gmii_txd;
				end
				rx_n++;
				in_frm = 1'b1;
			end else if (in_frm) begin
				check_frame(cyc - 1);
				in_frm = 1'b0;
				rx_n   = 0;
			end
		end
	end

endmodule

//--- design/video_udp_tx_top.sv
`timescale 1ns/1ps

module video_udp_tx_top (
	input  logic                   fifo_clk,
	input  logic                   sys_rst,
	input  logic                   line_valid,
	input  udp_tx_pkg::line_word_u line_word,
	output logic                   gmii_tx_en,
	output logic [7:0]             gmii_txd
);
	import udp_tx_pkg::*;

	logic [NUM_CH-1:0]      ln_wr;
	logic [LINE_NUM_W-1:0]  ln_num;
	logic [NUM_CH-1:0]      px_wr;
	line_word_u             px_word;
	logic [NUM_CH-1:0]      req;
	logic [NUM_CH-1:0]      gnt;
	logic [NUM_CH-1:0]      frm_en;
	logic [NUM_CH-1:0][7:0] frm_d;

	line_distributor i_line_distributor (
		.fifo_clk   (fifo_clk),
		.sys_rst    (sys_rst),
		.line_valid (line_valid),
		.line_word  (line_word),
		.ln_wr      (ln_wr),
		.ln_num     (ln_num),
		.px_wr      (px_wr),
		.px_word    (px_word)
	);

	// One builder per channel, addresses offset by its index
	for (genvar k = 0; k < NUM_CH; k++) begin : g_ch
		udp_frame_builder #(
			.CH_ID (k)
		) i_builder (
			.fifo_clk (fifo_clk),
			.sys_rst  (sys_rst),
			.ln_wr    (ln_wr[k]),
			.ln_num   (ln_num),
			.px_wr    (px_wr[k]),
			.px_word  (px_word),
			.gnt      (gnt[k]),
			.req      (req[k]),
			.frm_en   (frm_en[k]),
			.frm_d    (frm_d[k])
		);
	end

	gmii_frame_mux i_gmii_frame_mux (
		.fifo_clk   (fifo_clk),
		.sys_rst    (sys_rst),
		.req        (req),
		.frm_en     (frm_en),
		.frm_d      (frm_d),
		.gnt        (gnt),
		.gmii_tx_en (gmii_tx_en),
		.gmii_txd   (gmii_txd)
	);

endmodule

//--- design/gmii_frame_mux.sv
`timescale 1ns/1ps

module gmii_frame_mux (
	input  logic                                fifo_clk,
	input  logic                                sys_rst,
	input  logic [udp_tx_pkg::NUM_CH-1:0]       req,
	input  logic [udp_tx_pkg::NUM_CH-1:0]       frm_en,
	input  logic [udp_tx_pkg::NUM_CH-1:0][7:0]  frm_d,
	output logic [udp_tx_pkg::NUM_CH-1:0]       gnt,
	output logic                                gmii_tx_en,
	output logic [7:0]                          gmii_txd
);
	import udp_tx_pkg::*;

	logic [CH_W-1:0] ptr;
	logic [CH_W-1:0] pick;
	logic            found;

	// Round-robin search starting after the last grant
	always_comb begin
		int i;
		int idx;
		found = 1'b0;
		pick  = ptr;
		for (i = 1; i <= NUM_CH; i++) begin
			idx = (int'(ptr) + i) % NUM_CH;
			if (!found && req[idx]) begin
				found = 1'b1;
				pick  = CH_W'(idx);
			end
		end
	end

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			gnt        <= '0;
			ptr        <= CH_W'(NUM_CH - 1);
			gmii_tx_en <= 1'b0;
		end else begin
			if (gnt == '0) begin
				if (found) begin
					gnt <= NUM_CH'(1) << pick;
					ptr <= pick;
				end
			end else if ((req & gnt) == '0) begin
				// Frame done, one dead cycle before the next grant
				gnt <= '0;
			end
			gmii_tx_en <= |(frm_en & gnt);
		end
	end

	always_ff @(posedge fifo_clk) begin
		gmii_txd <= frm_d[ptr];
	end

	// Builders send bytes only while granted
	a_frm_in_gnt : assert property (@(posedge fifo_clk) disable iff (sys_rst)
		(frm_en & ~gnt) == '0);

endmodule

//--- design/udp_frame_builder.sv
`timescale 1ns/1ps

module udp_frame_builder #(
	parameter int CH_ID = 0
) (
	input  logic                              fifo_clk,
	input  logic                              sys_rst,
	input  logic                              ln_wr,
	input  logic [udp_tx_pkg::LINE_NUM_W-1:0] ln_num,
	input  logic                              px_wr,
	input  udp_tx_pkg::line_word_u            px_word,
	input  logic                              gnt,
	output logic                              req,
	output logic                              frm_en,
	output logic [7:0]                        frm_d
);
	import udp_tx_pkg::*;

	logic [3:0]            state;
	logic [5:0]            cnt;
	logic                  line_ready;
	line_word_u            head_px;
	logic [LINE_NUM_W-1:0] head_ln;
	logic                  rd_px;
	logic                  rd_line;
	logic                  crc_init;
	logic                  crc_en;
	logic [31:0]           crc;
	logic [7:0]            byte_nxt;
	logic [19:0]           ip_sum;
	logic [15:0]           ip_chk;
	logic [47:0]           dst_mac_ch;
	logic [47:0]           src_mac_ch;
	logic [31:0]           ip_src_ch;
	logic [31:0]           ip_dst_ch;
	logic [111:0]          eth_sh;
	logic [223:0]          ip_sh;
	logic [31:0]           crc_sh;
	logic [15:0]           ln_field;

	line_buffer i_line_buffer (
		.fifo_clk   (fifo_clk),
		.sys_rst    (sys_rst),
		.px_wr      (px_wr),
		.px_word    (px_word),
		.ln_wr      (ln_wr),
		.ln_num     (ln_num),
		.rd_px      (rd_px),
		.rd_line    (rd_line),
		.line_ready (line_ready),
		.head_px    (head_px),
		.head_ln    (head_ln)
	);

	// CRC follows the byte being loaded, so it is final when FCS starts
	crc32_gen i_crc32_gen (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.crc_init (crc_init),
		.crc_en   (crc_en),
		.data     (byte_nxt),
		.crc      (crc)
	);

	// --------------------
	// Per-channel addresses
	assign dst_mac_ch = {DST_MAC[47:8], DST_MAC[7:0] - 8'(CH_ID)};
	assign src_mac_ch = {SRC_MAC[47:8], SRC_MAC[7:0] + 8'(CH_ID)};
	assign ip_src_ch  = {IP_SRC[31:8], IP_SRC[7:0] + 8'(CH_ID)};
	assign ip_dst_ch  = {IP_DST[31:8], IP_DST[7:0] - 8'(CH_ID)};

	// Header bytes shifted so the current one is on top
	assign eth_sh   = {dst_mac_ch, src_mac_ch, ETH_TYPE} << {cnt, 3'b000};
	assign ip_sh    = {IP_VER_TOS, IP_LEN, IP_IDEN, IP_FLAG, IP_TTL, IP_PROT, ip_chk,
		ip_src_ch, ip_dst_ch, UDP_SRC_PORT, UDP_DST_PORT, UDP_LEN, 16'h0000} << {cnt, 3'b000};
	assign crc_sh   = crc << {cnt[1:0], 3'b000};
	assign ln_field = 16'(head_ln);

	always_comb begin
		case (state)
			ST_IDLE, ST_PRE: byte_nxt = 8'h55;
			ST_SFD:          byte_nxt = 8'hD5;
			ST_ETH:          byte_nxt = eth_sh[111:104];
			ST_IP:           byte_nxt = ip_sh[223:216];
			ST_TYPE:         byte_nxt = PKT_VIDEO;
			ST_LNUM:         byte_nxt = cnt[0] ? ln_field[7:0] : ln_field[15:8];
			ST_PIX:          byte_nxt = cnt[0] ? head_px.pix.chroma : head_px.pix.luma;
			ST_FCS:          byte_nxt = crc_sh[31:24];
			default:         byte_nxt = 8'h00;
		endcase
	end

	assign crc_en   = (state inside {ST_ETH, ST_IP, ST_TYPE, ST_LNUM, ST_PIX});
	assign crc_init = (state == ST_ETH) && (cnt == 6'd0);
	// One word popped per luma/chroma pair
	assign rd_px    = (state == ST_PIX) && cnt[0];
	assign rd_line  = (state == ST_PIX) && (cnt == 6'(2 * PIX_PER_LINE - 1));
	assign req      = (state == ST_IDLE) ? line_ready : ((state != ST_GAP) || frm_en);

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			state  <= ST_IDLE;
			cnt    <= '0;
			frm_en <= 1'b0;
		end else begin
			frm_en <= (state == ST_IDLE) ? gnt : (state != ST_GAP);
			cnt    <= cnt + 1'b1;
			case (state)
				ST_IDLE: begin
					cnt <= '0;
					if (gnt) begin
						state <= ST_PRE;
					end
				end
				ST_PRE:  if (cnt == 6'd5)  begin state <= ST_SFD;  cnt <= '0; end
				ST_SFD:  begin state <= ST_ETH; cnt <= '0; end
				ST_ETH:  if (cnt == 6'd13) begin state <= ST_IP;   cnt <= '0; end
				ST_IP:   if (cnt == 6'd27) begin state <= ST_TYPE; cnt <= '0; end
				ST_TYPE: begin state <= ST_LNUM; cnt <= '0; end
				ST_LNUM: if (cnt == 6'd1)  begin state <= ST_PIX;  cnt <= '0; end
				ST_PIX:  if (rd_line)      begin state <= ST_FCS;  cnt <= '0; end
				ST_FCS:  if (cnt == 6'd3)  begin state <= ST_GAP;  cnt <= '0; end
				ST_GAP: begin
					if (cnt == 6'(IFG_CYCLES)) begin
						state <= ST_IDLE;
						cnt   <= '0;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Header checksum folded during the preamble
	always_ff @(posedge fifo_clk) begin
		frm_d <= byte_nxt;
		if (state == ST_IDLE) begin
			ip_sum <= 20'(IP_VER_TOS) + 20'(IP_LEN) + 20'(IP_IDEN) + 20'(IP_FLAG)
				+ 20'({IP_TTL, IP_PROT}) + 20'(ip_src_ch[31:16]) + 20'(ip_src_ch[15:0])
				+ 20'(ip_dst_ch[31:16]) + 20'(ip_dst_ch[15:0]);
		end else if (state == ST_PRE && cnt < 6'd2) begin
			ip_sum <= {4'd0, ip_sum[15:0]} + 20'(ip_sum[19:16]);
		end else if (state == ST_PRE && cnt == 6'd2) begin
			ip_chk <= ~ip_sum[15:0];
		end
	end

endmodule

//--- design/crc32_gen.sv
`timescale 1ns/1ps

module crc32_gen (
	input  logic        fifo_clk,
	input  logic        sys_rst,
	input  logic        crc_init,
	input  logic        crc_en,
	input  logic [7:0]  data,
	output logic [31:0] crc
);
	import udp_tx_pkg::*;

	logic [31:0] crc_q;
	logic [31:0] seed;

	// Reflected CRC-32, LSB of the byte first
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		int          i;
		r = c;
		for (i = 0; i < 8; i++) begin
			r = (r[0] ^ d[i]) ? ((r >> 1) ^ CRC_POLY) : (r >> 1);
		end
		return r;
	endfunction

	// Init together with the first byte starts from all ones
	assign seed = crc_init ? 32'hFFFF_FFFF : crc_q;

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			crc_q <= 32'hFFFF_FFFF;
		end else if (crc_en) begin
			crc_q <= crc_byte(seed, data);
		end else if (crc_init) begin
			crc_q <= 32'hFFFF_FFFF;
		end
	end

	// First FCS byte on the wire sits in bits 31:24
	assign crc = ~{crc_q[7:0], crc_q[15:8], crc_q[23:16], crc_q[31:24]};

endmodule

//--- design/line_buffer.sv
`timescale 1ns/1ps

module line_buffer (
	input  logic                              fifo_clk,
	input  logic                              sys_rst,
	input  logic                              px_wr,
	input  udp_tx_pkg::line_word_u            px_word,
	input  logic                              ln_wr,
	input  logic [udp_tx_pkg::LINE_NUM_W-1:0] ln_num,
	input  logic                              rd_px,
	input  logic                              rd_line,
	output logic                              line_ready,
	output udp_tx_pkg::line_word_u            head_px,
	output logic [udp_tx_pkg::LINE_NUM_W-1:0] head_ln
);
	import udp_tx_pkg::*;

	line_word_u            mem [BUF_DEPTH];
	logic [LINE_NUM_W-1:0] ln_q [2];
	logic [BUF_AW:0]       wr_ptr;
	logic [BUF_AW:0]       rd_ptr;
	logic [BUF_AW:0]       fill;
	logic [1:0]            ln_wp;
	logic [1:0]            ln_rp;
	logic [PIX_CNT_W-1:0]  wr_cnt;
	logic [1:0]            done_cnt;
	logic                  line_done;

	assign fill      = wr_ptr - rd_ptr;
	assign line_done = px_wr && (wr_cnt == PIX_CNT_W'(PIX_PER_LINE - 1));

	always_ff @(posedge fifo_clk) begin
		if (px_wr) begin
			mem[wr_ptr[BUF_AW-1:0]] <= px_word;
		end
		if (ln_wr) begin
			ln_q[ln_wp[0]] <= ln_num;
		end
	end

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			ln_wp    <= '0;
			ln_rp    <= '0;
			wr_cnt   <= '0;
			done_cnt <= '0;
		end else begin
			if (px_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
				wr_cnt <= line_done ? '0 : wr_cnt + 1'b1;
			end
			if (rd_px) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (ln_wr) begin
				ln_wp <= ln_wp + 1'b1;
			end
			if (rd_line) begin
				ln_rp <= ln_rp + 1'b1;
			end
			// Complete lines waiting to be sent
			done_cnt <= done_cnt + 2'(line_done) - 2'(rd_line);
		end
	end

	assign line_ready = (done_cnt != 2'd0);
	assign head_px    = mem[rd_ptr[BUF_AW-1:0]];
	assign head_ln    = ln_q[ln_rp[0]];

	a_no_overflow : assert property (@(posedge fifo_clk) disable iff (sys_rst)
		(px_wr |-> fill != (BUF_AW+1)'(BUF_DEPTH)) and (ln_wr |-> (ln_wp - ln_rp) != 2'd2));

endmodule

//--- design/line_distributor.sv
`timescale 1ns/1ps

module line_distributor (
	input  logic                              fifo_clk,
	input  logic                              sys_rst,
	input  logic                              line_valid,
	input  udp_tx_pkg::line_word_u            line_word,
	output logic [udp_tx_pkg::NUM_CH-1:0]     ln_wr,
	output logic [udp_tx_pkg::LINE_NUM_W-1:0] ln_num,
	output logic [udp_tx_pkg::NUM_CH-1:0]     px_wr,
	output udp_tx_pkg::line_word_u            px_word
);
	import udp_tx_pkg::*;

	logic                 in_line;
	logic [PIX_CNT_W-1:0] pix_cnt;
	logic [CH_W-1:0]      ch_sel;
	logic                 is_hdr;
	logic [CH_W-1:0]      hdr_ch;

	assign is_hdr = (line_word.hdr.tag == HDR_TAG);
	// Target builder is line number modulo channel count
	assign hdr_ch = CH_W'(line_word.hdr.num % NUM_CH);

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			ln_wr   <= '0;
			px_wr   <= '0;
			in_line <= 1'b0;
			pix_cnt <= '0;
			ch_sel  <= '0;
		end else begin
			ln_wr <= '0;
			px_wr <= '0;
			if (line_valid) begin
				if (!in_line) begin
					// Words outside a line are dropped unless tagged
					if (is_hdr) begin
						ln_wr[hdr_ch] <= 1'b1;
						ch_sel        <= hdr_ch;
						pix_cnt       <= '0;
						in_line       <= 1'b1;
					end
				end else begin
					px_wr[ch_sel] <= 1'b1;
					pix_cnt       <= pix_cnt + 1'b1;
					if (pix_cnt == PIX_CNT_W'(PIX_PER_LINE - 1)) begin
						in_line <= 1'b0;
					end
				end
			end
		end
	end

	always_ff @(posedge fifo_clk) begin
		if (line_valid) begin
			ln_num  <= line_word.hdr.num;
			px_word <= line_word;
		end
	end

	a_hdr_after_line : assert property (@(posedge fifo_clk) disable iff (sys_rst)
		(line_valid && is_hdr) |-> !in_line);

endmodule

//--- design/udp_tx_pkg.sv
package udp_tx_pkg;

	// --------------------
	// Sizes
	localparam int NUM_CH       = 2;
	localparam int CH_W         = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;
	localparam int PIX_PER_LINE = 16;
	localparam int PIX_CNT_W    = $clog2(PIX_PER_LINE);
	localparam int LINE_NUM_W   = 11;
	localparam int BUF_DEPTH    = 2 * PIX_PER_LINE;
	localparam int BUF_AW       = $clog2(BUF_DEPTH);
	localparam int IFG_CYCLES   = 12;

	// Marks a header word in the top five bits
	localparam logic [4:0] HDR_TAG = 5'h1F;

	// --------------------
	// Frame fields
	localparam logic [47:0] SRC_MAC      = 48'h00_23_45_67_89_01;
	localparam logic [47:0] DST_MAC      = 48'h00_23_45_67_89_02;
	localparam logic [15:0] ETH_TYPE     = 16'h0800;
	localparam logic [31:0] IP_SRC       = {8'd192, 8'd168, 8'd0, 8'd1};
	localparam logic [31:0] IP_DST       = {8'd192, 8'd168, 8'd0, 8'd2};
	localparam logic [15:0] IP_VER_TOS   = 16'h4500;
	localparam logic [15:0] IP_IDEN      = 16'h0000;
	localparam logic [15:0] IP_FLAG      = 16'h4000;
	localparam logic [7:0]  IP_TTL       = 8'h40;
	localparam logic [7:0]  IP_PROT      = 8'h11;
	localparam logic [15:0] UDP_SRC_PORT = 16'h3038;
	localparam logic [15:0] UDP_DST_PORT = 16'h3039;
	localparam logic [7:0]  PKT_VIDEO    = 8'h00;
	// UDP header, type byte, line number, then luma/chroma pairs
	localparam logic [15:0] UDP_LEN      = 16'(8 + 3 + 2 * PIX_PER_LINE);
	localparam logic [15:0] IP_LEN       = UDP_LEN + 16'd20;
	localparam logic [31:0] CRC_POLY     = 32'hEDB88320;

	// --------------------
	// Builder phases
	localparam logic [3:0] ST_IDLE = 4'd0;
	localparam logic [3:0] ST_PRE  = 4'd1;
	localparam logic [3:0] ST_SFD  = 4'd2;
	localparam logic [3:0] ST_ETH  = 4'd3;
	localparam logic [3:0] ST_IP   = 4'd4;
	localparam logic [3:0] ST_TYPE = 4'd5;
	localparam logic [3:0] ST_LNUM = 4'd6;
	localparam logic [3:0] ST_PIX  = 4'd7;
	localparam logic [3:0] ST_FCS  = 4'd8;
	localparam logic [3:0] ST_GAP  = 4'd9;

	// One input word, read as a header or as a pixel
	typedef union packed {
		struct packed {
			logic [4:0]            tag;
			logic [LINE_NUM_W-1:0] num;
		} hdr;
		struct packed {
			logic [7:0] luma;
			logic [7:0] chroma;
		} pix;
	} line_word_u;

endpackage
